/* uart_alu.f */
src/uart_pkg.sv
src/alu_pkg.sv
src/baud_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/alu.sv
src/alu_uart_ctrl.sv
src/uart_alu_top.sv
testbench/tb_uart_alu.sv

/* Makefile */
# Verilator build and run of the serial calculator testbench

TOP := tb_uart_alu
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

obj_dir/V$(TOP): uart_alu.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f uart_alu.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "test: simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_uart_alu.sv */
`timescale 1ns/1ps

// Serial calculator testbench, bytes in on rxd, results back on txd
module tb_uart_alu;
	import alu_pkg::*;

	localparam int clks_per_tick  = 2;                   // Fast baud for simulation
	localparam int bit_cycles     = 16 * clks_per_tick;  // 16 ticks per bit
	localparam int frame_cycles   = 10 * bit_cycles;     // Start, 8 data, stop
	localparam int result_wait    = 2 * frame_cycles;    // Op stop to result stop, with room
	localparam int n_random       = 40;
	localparam int n_unknown      = 8;
	localparam int n_b2b          = 12;
	// Sweep, random, unknown, framing (two triples worth), back to back
	localparam int n_tests        = 8 + n_random + n_unknown + 2 + n_b2b;
	localparam int timeout_cycles = n_tests * 4 * 160 * clks_per_tick * 2;

	logic clk;
	logic arst_n;
	logic rxd;
	logic txd;
	logic frame_err;

	integer seed;
	int     cycles     = 0;
	int     mismatches = 0;
	int     failures   = 0;  // Missing or malformed responses
	int     fe_count   = 0;  // frame_err pulses seen

	logic [data_width-1:0] exp_q[$];  // Model results in send order
	logic [data_width-1:0] got_q[$];  // Bytes seen on txd
	logic                  stop_q[$]; // Their stop bits

	alu_op_e op_list [8] = '{op_add, op_sub, op_and, op_or, op_xor, op_nor, op_sra, op_srl};

	uart_alu_top #(
		.data_width   (data_width),
		.clks_per_tick(clks_per_tick)
	) DUT (
		.clk      (clk),
		.arst_n   (arst_n),
		.rxd      (rxd),
		.txd      (txd),
		.frame_err(frame_err)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	// Run length guard
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles)
		begin
			$display("Timeout: run went past %0d cycles without finishing", timeout_cycles);
			$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
			$display("=== FAIL ===");
			$finish;
		end
	end

	always @(negedge clk)
	begin
		if (arst_n === 1'b1 && frame_err === 1'b1)
			fe_count = fe_count + 1; // One per pulse
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [data_width-1:0] model_alu(
		input logic [data_width-1:0] a,
		input logic [data_width-1:0] b,
		input logic [op_width-1:0]   op
	);
		logic [2:0]            sh;
		logic [data_width-1:0] fill; // Sign bits shifted in from the top
		sh   = b[2:0];
		fill = a[data_width-1] ? ~({data_width{1'b1}} >> sh) : '0;
		case (op)
			6'b100000: model_alu = a + b;
			6'b100010: model_alu = a + ~b + 1'b1; // Two's complement
			6'b100100: model_alu = a & b;
			6'b100101: model_alu = a | b;
			6'b100110: model_alu = a ^ b;
			6'b100111: model_alu = ~a & ~b;       // De Morgan
			6'b000011: model_alu = (a >> sh) | fill;
			6'b000010: model_alu = a >> sh;
			default:   model_alu = '0;
		endcase
	endfunction

	function automatic logic is_defined(input logic [op_width-1:0] op);
		int j;
		is_defined = 1'b0;
		for (j = 0; j < 8; j++)
			if (op == op_list[j])
				is_defined = 1'b1;
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_result(input logic [data_width-1:0] got, input logic [data_width-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_stop(input logic got);
		if (got !== 1'b1)
		begin
			$display("MISMATCH at %0t: stop bit on txd was %b", $time, got);
			mismatches++;
		end
	endtask

	task automatic check_frame_err(input logic exp, input logic got, input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
			mismatches++;
		end
	endtask

	// Idle level of txd
	task automatic check_line(input logic got, input string what);
		if (got !== 1'b1)
		begin
			$display("MISMATCH at %0t: %s got %b expected 1", $time, what, got);
			mismatches++;
		end
	endtask

	////////////////////////////////////////
	// Serial driver
	////////////////////////////////////////

	// Called on a falling edge, returns on one
	task automatic send_byte(input logic [data_width-1:0] data, input logic bad_stop);
		int j;
		rxd = 1'b0; // Start bit
		repeat (bit_cycles) @(negedge clk);
		for (j = 0; j < data_width; j++)
		begin
			rxd = data[j]; // LSB first
			repeat (bit_cycles) @(negedge clk);
		end
		rxd = ~bad_stop;
		repeat (bit_cycles) @(negedge clk);
		if (bad_stop)
		begin
			rxd = 1'b1; // Give the next start bit an edge
			repeat (bit_cycles) @(negedge clk);
		end
	endtask

	task automatic send_triple(input logic [data_width-1:0] a, input logic [data_width-1:0] b,
		input logic [data_width-1:0] op);
		exp_q.push_back(model_alu(a, b, op[op_width-1:0])); // Top bits ignored
		send_byte(a, 1'b0);
		send_byte(b, 1'b0);
		send_byte(op, 1'b0);
	endtask

	// Wait for n bytes from the monitor, then compare in order
	task automatic expect_results(input int n);
		int                    waited;
		int                    j;
		logic [data_width-1:0] got;
		waited = 0;
		while (got_q.size() < n && waited < result_wait + frame_cycles)
		begin
			@(negedge clk);
			waited++;
		end
		if (got_q.size() < n)
		begin
			$display("At %0t: expected %0d result bytes on txd, only %0d arrived",
				$time, n, got_q.size());
			failures++;
			got_q.delete();
			stop_q.delete();
			exp_q.delete();
		end
		else
			for (j = 0; j < n; j++)
			begin
				got = got_q.pop_front();
				check_result(got, exp_q.pop_front(), "result byte");
				check_stop(stop_q.pop_front());
			end
	endtask

	////////////////////////////////////////
	// Serial monitor
	////////////////////////////////////////

	initial
	begin : serial_monitor
		logic [data_width-1:0] rx_byte;
		logic                  stop_bit;
		int                    j;
		forever
		begin
			@(negedge txd);
			repeat (bit_cycles / 2) @(negedge clk); // Middle of start bit
			if (txd !== 1'b0)
			begin
				$display("At %0t: start bit on txd ended before mid-bit", $time);
				failures++;
			end
			for (j = 0; j < data_width; j++)
			begin
				repeat (bit_cycles) @(negedge clk);
				rx_byte[j] = txd;
			end
			repeat (bit_cycles) @(negedge clk);
			stop_bit = txd;
			got_q.push_back(rx_byte);
			stop_q.push_back(stop_bit);
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin : main_seq
		int                    i;
		int                    k;
		int                    fe_before;
		logic [data_width-1:0] a_v;
		logic [data_width-1:0] b_v;
		logic [data_width-1:0] op_v;

		seed   = 32'h739c2ec5;
		rxd    = 1'b1; // Line idle
		arst_n = 1'b0;

		// Quiet outputs in and after reset
		repeat (3)
		begin
			@(negedge clk);
			check_line(txd, "txd during reset");
			check_frame_err(1'b0, frame_err, "frame_err during reset");
		end
		arst_n = 1'b1;
		repeat (2 * bit_cycles)
		begin
			@(negedge clk);
			check_line(txd, "txd after reset");
			check_frame_err(1'b0, frame_err, "frame_err after reset");
		end

		// Each opcode once, junk in the spare bits
		for (i = 0; i < 8; i++)
		begin
			a_v  = data_width'($random(seed));
			b_v  = data_width'($random(seed));
			op_v = {2'($random(seed)), op_list[i]};
			send_triple(a_v, b_v, op_v);
			expect_results(1);
		end

		for (i = 0; i < n_random; i++)
		begin
			k    = $unsigned($random(seed)) % 8;
			a_v  = data_width'($random(seed));
			b_v  = data_width'($random(seed));
			op_v = {2'($random(seed)), op_list[k]};
			send_triple(a_v, b_v, op_v);
			expect_results(1);
		end

		// Undefined opcodes give zero
		for (i = 0; i < n_unknown; i++)
		begin
			a_v = data_width'($random(seed));
			b_v = data_width'($random(seed));
			do
				op_v = data_width'($random(seed));
			while (is_defined(op_v[op_width-1:0]));
			send_triple(a_v, b_v, op_v);
			expect_results(1);
		end
		check_frame_err(1'b0, fe_count != 0, "frame_err on clean frames");

		// Low stop bit on B aborts the triple
		fe_before = fe_count;
		send_byte(data_width'($random(seed)), 1'b0);
		send_byte(data_width'($random(seed)), 1'b1);
		check_frame_err(1'b1, fe_count == fe_before + 1, "single frame_err on low stop");
		repeat (result_wait) @(negedge clk);
		if (got_q.size() != 0)
		begin
			$display("At %0t: a result came back for the aborted triple", $time);
			failures++;
			got_q.delete();
			stop_q.delete();
		end
		a_v  = data_width'($random(seed));
		b_v  = data_width'($random(seed));
		op_v = {2'b00, op_list[$unsigned($random(seed)) % 8]};
		send_triple(a_v, b_v, op_v); // Counter back at A
		expect_results(1);

		// No idle gap, results overlap the next triple
		for (i = 0; i < n_b2b; i++)
		begin
			k    = $unsigned($random(seed)) % 8;
			a_v  = data_width'($random(seed));
			b_v  = data_width'($random(seed));
			op_v = {2'($random(seed)), op_list[k]};
			send_triple(a_v, b_v, op_v);
		end
		expect_results(n_b2b);
		repeat (result_wait) @(negedge clk);
		if (got_q.size() != 0)
		begin
			$display("At %0t: %0d extra result bytes after back to back triples",
				$time, got_q.size());
			failures++;
		end
		check_frame_err(1'b0, fe_count != fe_before + 1, "frame_err on back to back frames");

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* src/uart_alu_top.sv */
`timescale 1ns/1ps

// Serial calculator, A B Op in, one result byte out
module uart_alu_top #(
	parameter int data_width    = alu_pkg::data_width,
	parameter int clks_per_tick = 54
) (
	input  logic clk,
	input  logic arst_n,
	input  logic rxd,       // UART in
	output logic txd,       // UART out
	output logic frame_err  // Bad stop bit seen
);
	import alu_pkg::*;

	logic                  tick;
	logic [data_width-1:0] rx_data;
	logic                  rx_done;
	logic [data_width-1:0] a;
	logic [data_width-1:0] b;
	alu_op_e               op;
	logic [data_width-1:0] result;
	logic [data_width-1:0] tx_data;
	logic                  tx_start;
	logic                  tx_busy;

	baud_gen #(.clks_per_tick(clks_per_tick)) u_baud_gen (
		.clk   (clk),
		.arst_n(arst_n),
		.tick  (tick)
	);

	uart_rx #(.data_width(data_width)) u_uart_rx (
		.clk      (clk),
		.arst_n   (arst_n),
		.tick     (tick),
		.rxd      (rxd),
		.rx_data  (rx_data),
		.rx_done  (rx_done),
		.frame_err(frame_err)
	);

	alu_uart_ctrl #(.data_width(data_width)) u_ctrl (
		.clk      (clk),
		.arst_n   (arst_n),
		.rx_done  (rx_done),
		.frame_err(frame_err),
		.rx_data  (rx_data),
		.result   (result),
		.tx_busy  (tx_busy),
		.a        (a),
		.b        (b),
		.op       (op),
		.tx_data  (tx_data),
		.tx_start (tx_start)
	);

	alu #(.data_width(data_width)) u_alu (
		.a     (a),
		.b     (b),
		.op    (op),
		.result(result)
	);

	uart_tx #(.data_width(data_width)) u_uart_tx (
		.clk     (clk),
		.arst_n  (arst_n),
		.tick    (tick),
		.tx_start(tx_start),
		.tx_data (tx_data),
		.txd     (txd),
		.tx_busy (tx_busy)
	);

endmodule

/* src/alu_uart_ctrl.sv */
`timescale 1ns/1ps

// Byte sequencer between UART and ALU
module alu_uart_ctrl #(
	parameter int data_width = alu_pkg::data_width
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  rx_done,   // Byte received
	input  logic                  frame_err, // Bad stop bit
	input  logic [data_width-1:0] rx_data,
	input  logic [data_width-1:0] result,    // From ALU
	input  logic                  tx_busy,
	output logic [data_width-1:0] a,
	output logic [data_width-1:0] b,
	output alu_pkg::alu_op_e      op,
	output logic [data_width-1:0] tx_data,   // Result register
	output logic                  tx_start
);
	import alu_pkg::*;

	// Sequence counter values
	localparam logic [1:0] seq_a  = 2'd0;
	localparam logic [1:0] seq_b  = 2'd1;
	localparam logic [1:0] seq_op = 2'd2;

	logic [1:0] seq_cnt;   // Which byte comes next
	logic       op_loaded; // Op just written, ALU settles this cycle
	logic       pending;   // Result waiting for transmitter

	////////////////////////////////////////
	// Byte sequencing
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			seq_cnt   <= seq_a;
			op_loaded <= 1'b0;
		end
		else
		begin
			op_loaded <= 1'b0;
			if (frame_err)
				seq_cnt <= seq_a; // Resync, next byte is A
			else if (rx_done)
			begin
				if (seq_cnt == seq_op)
				begin
					seq_cnt   <= seq_a; // Triple complete
					op_loaded <= 1'b1;
				end
				else
					seq_cnt <= seq_cnt + 1'b1;
			end
		end
	end

	// Operand registers, untouched by frame errors
	always_ff @(posedge clk)
	begin
		if (rx_done)
			case (seq_cnt)
				seq_a:   a  <= rx_data;
				seq_b:   b  <= rx_data;
				seq_op:  op <= alu_op_e'(rx_data[op_width-1:0]); // Top bits ignored
				default: ;
			endcase
	end

	////////////////////////////////////////
	// Result and transmit start
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (op_loaded)
			tx_data <= result; // Newer triple overwrites
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pending <= 1'b0;
		else if (op_loaded)
			pending <= 1'b1;
		else if (tx_start)
			pending <= 1'b0;
	end

	assign tx_start = pending & ~tx_busy; // Single pulse, busy follows

	a_seq_range: assert property (@(posedge clk) disable iff (!arst_n)
		seq_cnt != 2'd3);

	// Result leaves only through a transmit
	a_pending_clear: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(pending) |-> $past(tx_start));

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

// Combinational ALU
module alu #(
	parameter int data_width = alu_pkg::data_width
) (
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  alu_pkg::alu_op_e      op,
	output logic [data_width-1:0] result
);
	import alu_pkg::*;

	logic [2:0] shamt; // Shift distance from B

	assign shamt = b[2:0];

	always_comb
	begin
		case (op)
			op_add: result = a + b;          // Carry dropped
			op_sub: result = a - b;
			op_and: result = a & b;
			op_or:  result = a | b;
			op_xor: result = a ^ b;
			op_nor: result = ~(a | b);
			op_sra: result = $signed(a) >>> shamt; // Sign fill
			op_srl: result = a >> shamt;
			default: result = '0;            // Undefined opcode
		endcase
	end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps

// UART transmitter, start + data LSB first + stop
module uart_tx #(
	parameter int data_width = alu_pkg::data_width
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  tick,     // Oversampling strobe
	input  logic                  tx_start, // One cycle, only while idle
	input  logic [data_width-1:0] tx_data,  // Latched on tx_start
	output logic                  txd,      // Serial out
	output logic                  tx_busy   // Frame in flight
);
	import uart_pkg::*;

	localparam int stop_ticks = oversample * stop_bits;
	localparam int cnt_w = $clog2(stop_ticks);
	localparam int bit_w = (data_width > 1) ? $clog2(data_width) : 1;
	localparam logic [cnt_w-1:0] bit_end  = cnt_w'(oversample - 1);
	localparam logic [cnt_w-1:0] stop_end = cnt_w'(stop_ticks - 1);
	localparam logic [bit_w-1:0] last_bit = bit_w'(data_width - 1);

	uart_state_e           state;
	logic [cnt_w-1:0]      tick_cnt; // Line changes at count zero
	logic [bit_w-1:0]      bit_cnt;
	logic [data_width-1:0] shift;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= st_idle;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			txd      <= 1'b1; // Mark level
			tx_busy  <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					txd      <= 1'b1;
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (tx_start)
					begin
						tx_busy <= 1'b1;
						state   <= st_start;
					end
				end
				st_start:
					if (tick)
					begin
						if (tick_cnt == '0)
							txd <= 1'b0; // First tick after start
						if (tick_cnt == bit_end)
						begin
							tick_cnt <= '0;
							state    <= st_data;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				st_data:
					if (tick)
					begin
						if (tick_cnt == '0)
							txd <= shift[0];
						if (tick_cnt == bit_end)
						begin
							tick_cnt <= '0;
							if (bit_cnt == last_bit)
								state <= st_stop;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				st_stop:
					if (tick)
					begin
						if (tick_cnt == '0)
							txd <= 1'b1;
						if (tick_cnt == stop_end)
						begin
							tick_cnt <= '0;
							tx_busy  <= 1'b0; // Next start lands a full bit later
							state    <= st_idle;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				default: state <= st_idle;
			endcase
		end
	end

	// Payload shifter
	always_ff @(posedge clk)
	begin
		if (state == st_idle && tx_start)
			shift <= tx_data;
		else if (state == st_data && tick && tick_cnt == '0)
			shift <= shift >> 1; // Bit 0 just went out
	end

	// Controller must hold off while a frame is out
	a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
		tx_start |-> !tx_busy);

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

// 16x oversampling UART receiver, 8N1
module uart_rx #(
	parameter int data_width = alu_pkg::data_width
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  tick,      // Oversampling strobe
	input  logic                  rxd,       // Serial in, idles high
	output logic [data_width-1:0] rx_data,   // Valid with rx_done
	output logic                  rx_done,   // Good frame, one cycle
	output logic                  frame_err  // Stop bit low, one cycle
);
	import uart_pkg::*;

	localparam int cnt_w = $clog2(oversample);
	localparam int bit_w = (data_width > 1) ? $clog2(data_width) : 1;
	localparam logic [cnt_w-1:0] mid_tick = cnt_w'(oversample / 2 - 1);
	localparam logic [cnt_w-1:0] end_tick = cnt_w'(oversample - 1);
	localparam logic [bit_w-1:0] last_bit = bit_w'(data_width - 1);

	uart_state_e           state;
	logic [cnt_w-1:0]      tick_cnt; // Ticks into current bit
	logic [bit_w-1:0]      bit_cnt;  // Data bit index
	logic [data_width-1:0] shift;
	logic                  rxd_meta;
	logic                  rxd_sync;
	logic                  rxd_last; // Previous synced level
	logic                  fall;     // Start edge

	////////////////////////////////////////
	// Input synchronizer
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rxd_meta <= 1'b1; // Line idles high
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	// Edge, not level, so a line stuck low after a bad stop is not a new start
	assign fall = rxd_last & ~rxd_sync;

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= st_idle;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			rx_done   <= 1'b0;
			frame_err <= 1'b0;
		end
		else
		begin
			rx_done   <= 1'b0; // Pulses by default
			frame_err <= 1'b0;
			case (state)
				st_idle:
				begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (fall)
						state <= st_start;
				end
				st_start:
					if (tick)
					begin
						if (tick_cnt == mid_tick)
						begin
							tick_cnt <= '0;
							// Middle of start bit, reject glitches
							state    <= rxd_sync ? st_idle : st_data;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				st_data:
					if (tick)
					begin
						if (tick_cnt == end_tick) // Mid data bit
						begin
							tick_cnt <= '0;
							if (bit_cnt == last_bit)
								state <= st_stop;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				st_stop:
					if (tick)
					begin
						if (tick_cnt == end_tick) // Mid stop bit
						begin
							tick_cnt <= '0;
							state    <= st_idle;
							if (rxd_sync)
								rx_done <= 1'b1;
							else
								frame_err <= 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				default: state <= st_idle;
			endcase
		end
	end

	// Sample in LSB first
	always_ff @(posedge clk)
	begin
		if (state == st_data && tick && tick_cnt == end_tick)
			shift <= {rxd_sync, shift[data_width-1:1]};
	end

	assign rx_data = shift; // Holds until next frame's first data bit

	// One stop sample, one outcome
	a_done_err_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(rx_done && frame_err));

endmodule

/* src/baud_gen.sv */
`timescale 1ns/1ps

// Oversampling strobe for both UART directions
module baud_gen #(
	parameter int clks_per_tick = 54 // 100 MHz / (115200 * 16)
) (
	input  logic clk,
	input  logic arst_n,
	output logic tick // One cycle high per period
);

	localparam int cnt_w = (clks_per_tick > 1) ? $clog2(clks_per_tick) : 1;
	localparam logic [cnt_w-1:0] reload = cnt_w'(clks_per_tick - 1);

	logic [cnt_w-1:0] cnt; // Cycles left in this period

	// Free running down counter
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt  <= reload;
			tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt  <= reload; // Wrap and strobe
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* src/alu_pkg.sv */
// Datapath widths and opcode map of the calculator
package alu_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int data_width = 8; // Operands and result
	localparam int op_width   = 6; // Low bits of the opcode byte

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////

	// MIPS funct style encoding
	typedef enum logic [op_width-1:0] {
		op_add = 6'b100000, // A + B
		op_sub = 6'b100010, // A - B
		op_and = 6'b100100, // A & B
		op_or  = 6'b100101, // A | B
		op_xor = 6'b100110, // A ^ B
		op_nor = 6'b100111, // ~(A | B)
		op_sra = 6'b000011, // A >>> B[2:0], sign fill
		op_srl = 6'b000010  // A >> B[2:0], zero fill
	} alu_op_e;

	// Anything else decodes to a zero result

endpackage

/* src/uart_pkg.sv */
// UART framing shared by receiver and transmitter
package uart_pkg;

	////////////////////////////////////////
	// Framing
	////////////////////////////////////////

	localparam int oversample = 16; // Ticks per bit
	localparam int stop_bits  = 1;  // No parity, one stop

	////////////////////////////////////////
	// Line state machine
	////////////////////////////////////////

	// Same four phases in both directions
	typedef enum logic [1:0] {
		st_idle  = 2'b00, // Line high, waiting
		st_start = 2'b01, // Start bit
		st_data  = 2'b10, // Data bits, LSB first
		st_stop  = 2'b11  // Stop bit
	} uart_state_e;

endpackage
